/* rtl/flmem_pkg.sv */
package flmem_pkg;

  localparam int DATA_W     = 16;
  localparam int NUM_BANKS  = 4;
  localparam int BANK_BITS  = 2;
  localparam int NUM_ROWS   = 16;
  localparam int ROW_BITS   = 4;
  localparam int ADDR_BITS  = BANK_BITS + ROW_BITS;
  localparam int CNT_BITS   = 5;    // must hold NUM_ROWS.
  localparam int READ_DELAY = 2;
  localparam int FL_RESERVE = 1;    // rows a bank never hands out.

  typedef struct packed {
    logic [BANK_BITS-1:0] bank;
    logic [ROW_BITS-1:0]  row;
  } bank_row_t;

  typedef union packed {
    logic [ADDR_BITS-1:0] flat;
    bank_row_t            split;
  } mem_addr_u;

  typedef struct packed {
    logic              en;
    mem_addr_u         addr;
    logic [DATA_W-1:0] data;
  } wr_req_t;

  typedef struct packed {
    logic      en;
    mem_addr_u addr;
  } rd_req_t;

  typedef struct packed {
    logic      en;
    mem_addr_u addr;
  } dq_req_t;

  typedef struct packed {
    logic              en;
    logic [DATA_W-1:0] data;
  } ma_req_t;

  typedef struct packed {
    logic      vld;
    mem_addr_u addr;
  } ma_resp_t;

  typedef struct packed {
    logic              vld;
    logic [DATA_W-1:0] data;
  } rd_resp_t;

endpackage

/* rtl/init_sequencer.sv */
`timescale 1ns/10ps

module init_sequencer (
  input  logic                          clk,
  input  logic                          rst,
  output logic                          init_act,
  output logic [flmem_pkg::ROW_BITS-1:0] init_row,
  output logic                          ready
);
  import flmem_pkg::*;

  logic walking;

  always_ff @(posedge clk) begin
    if (rst) begin
      init_row <= '0;
      walking  <= 1'b1;
      ready    <= 1'b0;
    end else if (walking) begin
      if (init_row == ROW_BITS'(NUM_ROWS - 1)) begin
        walking <= 1'b0; // last row linked.
        ready   <= 1'b1;
      end else begin
        init_row <= init_row + 1'b1;
      end
    end
  end

  assign init_act = walking;

endmodule

/* rtl/bank_free_list.sv */
`timescale 1ns/10ps

module bank_free_list (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           init_act,
  input  logic [flmem_pkg::ROW_BITS-1:0] init_row,
  input  logic                           pop,
  input  logic                           push,
  input  logic [flmem_pkg::ROW_BITS-1:0] push_row,
  output logic [flmem_pkg::ROW_BITS-1:0] head_row,
  output logic                           avail
);
  import flmem_pkg::*;

  logic [ROW_BITS-1:0] link_mem [NUM_ROWS];
  logic [ROW_BITS-1:0] head;
  logic [ROW_BITS-1:0] tail;
  logic [CNT_BITS-1:0] count;
  logic [CNT_BITS-1:0] count_nxt;

  // row r points at r+1 during init and the tail points at a pushed row after.
  always_ff @(posedge clk) begin
    if (init_act) begin
      link_mem[init_row] <= init_row + 1'b1;
    end else if (push) begin
      link_mem[tail] <= push_row;
    end
  end

  always_comb begin
    count_nxt = count;
    if (push) begin
      count_nxt = count_nxt + 1'b1;
    end
    if (pop) begin
      count_nxt = count_nxt - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      head  <= '0;
      tail  <= ROW_BITS'(NUM_ROWS - 1);
      count <= CNT_BITS'(NUM_ROWS);
    end else begin
      if (pop) begin
        head <= link_mem[head]; // follow the list.
      end
      if (push) begin
        tail <= push_row;
      end
      count <= count_nxt;
    end
  end

  // the reserve keeps head and tail apart when pop and push coincide
  assign avail    = (count > CNT_BITS'(FL_RESERVE));
  assign head_row = head;

endmodule

/* rtl/alloc_arbiter.sv */
`timescale 1ns/10ps

module alloc_arbiter (
  input  logic                                                 clk,
  input  logic                                                 rst,
  input  logic                                                 ma_en,
  input  logic [flmem_pkg::NUM_BANKS-1:0]                      avail,
  input  logic                                                 wr_en,
  input  logic [flmem_pkg::BANK_BITS-1:0]                      wr_bank,
  input  logic [flmem_pkg::NUM_BANKS-1:0][flmem_pkg::ROW_BITS-1:0] head_rows,
  output logic [flmem_pkg::NUM_BANKS-1:0]                      pop,
  output logic                                                 ma_bp,
  output flmem_pkg::ma_resp_t                                  ma_resp
);
  import flmem_pkg::*;

  logic [NUM_BANKS-1:0] wr_mask;
  logic [NUM_BANKS-1:0] elig;
  logic [BANK_BITS-1:0] sel;
  logic                 grant;
  logic                 grant_vld;
  mem_addr_u            grant_addr;

  // the write owns its bank's data port this cycle.
  always_comb begin
    wr_mask = '0;
    if (wr_en) begin
      wr_mask[wr_bank] = 1'b1;
    end
    elig = avail & ~wr_mask;
  end

  // lowest eligible bank wins.
  always_comb begin
    sel = '0;
    for (int i = NUM_BANKS - 1; i >= 0; i--) begin
      if (elig[i]) begin
        sel = BANK_BITS'(i);
      end
    end
  end

  assign ma_bp = ~|elig;
  assign grant = ma_en & ~ma_bp;

  always_comb begin
    pop = '0;
    if (grant) begin
      pop[sel] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      grant_vld <= 1'b0;
    end else begin
      grant_vld <= grant;
    end
  end

  always_ff @(posedge clk) begin
    if (grant) begin
      grant_addr.flat <= {sel, head_rows[sel]};
    end
  end

  assign ma_resp = '{vld: grant_vld, addr: grant_addr};

endmodule

/* rtl/bank_data_mem.sv */
`timescale 1ns/10ps

module bank_data_mem (
  input  logic                           clk,
  input  logic                           we,
  input  logic [flmem_pkg::ROW_BITS-1:0] waddr,
  input  logic [flmem_pkg::DATA_W-1:0]   wdata,
  input  logic [flmem_pkg::ROW_BITS-1:0] raddr,
  output logic [flmem_pkg::DATA_W-1:0]   rdata
);
  import flmem_pkg::*;

  logic [DATA_W-1:0] mem [NUM_ROWS];

  // read-first on a same-row collision.
  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
    rdata <= mem[raddr];
  end

endmodule

/* rtl/read_return.sv */
`timescale 1ns/10ps

module read_return (
  input  logic                                                clk,
  input  logic                                                rst,
  input  logic                                                rd_en,
  input  logic [flmem_pkg::BANK_BITS-1:0]                     rd_bank,
  input  logic [flmem_pkg::NUM_BANKS-1:0][flmem_pkg::DATA_W-1:0] bank_rdata,
  output flmem_pkg::rd_resp_t                                 rd_resp
);
  import flmem_pkg::*;

  logic                 en_q;
  logic [BANK_BITS-1:0] bank_q;
  logic                 vld_q;
  logic [DATA_W-1:0]    data_q;

  // stage one lines up with the memory's registered read.
  always_ff @(posedge clk) begin
    if (rst) begin
      en_q  <= 1'b0;
      vld_q <= 1'b0;
    end else begin
      en_q  <= rd_en;
      vld_q <= en_q;
    end
  end

  always_ff @(posedge clk) begin
    bank_q <= rd_bank;
    data_q <= bank_rdata[bank_q]; // pick the bank that was read.
  end

  assign rd_resp = '{vld: vld_q, data: data_q};

endmodule

/* rtl/flmem_top.sv */
`timescale 1ns/10ps

module flmem_top (
  input  logic                clk,
  input  logic                rst,
  input  flmem_pkg::ma_req_t  ma_req,
  input  flmem_pkg::wr_req_t  wr_req,
  input  flmem_pkg::rd_req_t  rd_req,
  input  flmem_pkg::dq_req_t  dq_req,
  output flmem_pkg::ma_resp_t ma_resp,
  output logic                ma_bp,
  output flmem_pkg::rd_resp_t rd_resp,
  output logic                ready
);
  import flmem_pkg::*;

  ma_req_t ma_g;
  wr_req_t wr_g;
  rd_req_t rd_g;
  dq_req_t dq_g;

  logic                init_act;
  logic [ROW_BITS-1:0] init_row;

  logic [NUM_BANKS-1:0]               avail;
  logic [NUM_BANKS-1:0]               pop;
  logic [NUM_BANKS-1:0]               push;
  logic [NUM_BANKS-1:0][ROW_BITS-1:0] head_rows;
  logic [NUM_BANKS-1:0][DATA_W-1:0]   bank_rdata;

  // nothing gets in until the lists are built.
  always_comb begin
    ma_g    = ma_req;
    ma_g.en = ma_req.en & ready;
    wr_g    = wr_req;
    wr_g.en = wr_req.en & ready;
    rd_g    = rd_req;
    rd_g.en = rd_req.en & ready;
    dq_g    = dq_req;
    dq_g.en = dq_req.en & ready;
  end

  init_sequencer u_init (
    .clk      (clk),
    .rst      (rst),
    .init_act (init_act),
    .init_row (init_row),
    .ready    (ready)
  );

  alloc_arbiter u_arb (
    .clk       (clk),
    .rst       (rst),
    .ma_en     (ma_g.en),
    .avail     (avail),
    .wr_en     (wr_g.en),
    .wr_bank   (wr_g.addr.split.bank),
    .head_rows (head_rows),
    .pop       (pop),
    .ma_bp     (ma_bp),
    .ma_resp   (ma_resp)
  );

  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    logic                wr_hit;
    logic                we;
    logic [ROW_BITS-1:0] waddr;
    logic [DATA_W-1:0]   wdata;

    assign push[b] = dq_g.en && (dq_g.addr.split.bank == BANK_BITS'(b));
    assign wr_hit  = wr_g.en && (wr_g.addr.split.bank == BANK_BITS'(b));

    // an allocation lands at the head row it just popped.
    assign we    = wr_hit | pop[b];
    assign waddr = pop[b] ? head_rows[b] : wr_g.addr.split.row;
    assign wdata = pop[b] ? ma_g.data : wr_g.data;

    bank_free_list u_fl (
      .clk      (clk),
      .rst      (rst),
      .init_act (init_act),
      .init_row (init_row),
      .pop      (pop[b]),
      .push     (push[b]),
      .push_row (dq_g.addr.split.row),
      .head_row (head_rows[b]),
      .avail    (avail[b])
    );

    bank_data_mem u_mem (
      .clk   (clk),
      .we    (we),
      .waddr (waddr),
      .wdata (wdata),
      .raddr (rd_g.addr.split.row),
      .rdata (bank_rdata[b])
    );
  end

  read_return u_rret (
    .clk        (clk),
    .rst        (rst),
    .rd_en      (rd_g.en),
    .rd_bank    (rd_g.addr.split.bank),
    .bank_rdata (bank_rdata),
    .rd_resp    (rd_resp)
  );

endmodule

/* test/tb_flmem.sv */
`timescale 1ns/10ps

module tb_flmem;
  import flmem_pkg::*;

  localparam int MAX_CYCLES = 2000; // well past the whole sequence.

  logic     clk;
  logic     rst;
  ma_req_t  ma_req;
  wr_req_t  wr_req;
  rd_req_t  rd_req;
  dq_req_t  dq_req;
  ma_resp_t ma_resp;
  logic     ma_bp;
  rd_resp_t rd_resp;
  logic     ready;

  // one circular queue of free rows per bank.
  logic [ROW_BITS-1:0]  fl_rows [NUM_BANKS][NUM_ROWS];
  int                   fl_head [NUM_BANKS];
  int                   fl_cnt  [NUM_BANKS];
  logic [DATA_W-1:0]    shadow  [NUM_BANKS*NUM_ROWS];
  logic [ADDR_BITS-1:0] last_grant;
  logic [15:0]          lfsr;

  ma_resp_t ma_exp;
  rd_resp_t rd_exp;
  logic     bp_exp;
  ma_resp_t ma_pipe;
  rd_resp_t rd_pipe [2];

  int ma_errs;
  int rd_errs;
  int bp_errs;
  int misc_errs;
  int cycles;

  flmem_top dut (
    .clk     (clk),
    .rst     (rst),
    .ma_req  (ma_req),
    .wr_req  (wr_req),
    .rd_req  (rd_req),
    .dq_req  (dq_req),
    .ma_resp (ma_resp),
    .ma_bp   (ma_bp),
    .rd_resp (rd_resp),
    .ready   (ready)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  // x^16 + x^14 + x^13 + x^11 + 1.
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic rand_bits(input int n, output logic [15:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[14:0], lfsr[0]};
    end
  endtask

  // lowest bank above its reserve that is not being written.
  function automatic int ref_alloc(input logic wr_en, input logic [BANK_BITS-1:0] wr_bank);
    for (int i = 0; i < NUM_BANKS; i++) begin
      if (fl_cnt[i] > FL_RESERVE && !(wr_en && wr_bank == i)) begin
        return i;
      end
    end
    return -1;
  endfunction

  task automatic model_reset();
    for (int b = 0; b < NUM_BANKS; b++) begin
      for (int r = 0; r < NUM_ROWS; r++) begin
        fl_rows[b][r] = ROW_BITS'(r);
      end
      fl_head[b] = 0;
      fl_cnt[b]  = NUM_ROWS;
    end
  endtask

  task automatic drive_idle();
    ma_req = '0;
    wr_req = '0;
    rd_req = '0;
    dq_req = '0;
    ma_exp = '0;
    rd_exp = '0;
    bp_exp = (ref_alloc(1'b0, '0) < 0);
  endtask

  // drives one clock of requests and updates the model as the DUT will be at the edge.
  task automatic step(input logic ma_en, input logic [DATA_W-1:0] ma_data,
                      input logic wr_en, input logic [ADDR_BITS-1:0] wr_addr,
                      input logic [DATA_W-1:0] wr_data,
                      input logic rd_en, input logic [ADDR_BITS-1:0] rd_addr,
                      input logic dq_en, input logic [ADDR_BITS-1:0] dq_addr);
    int        b;
    int        qb;
    mem_addr_u wa;
    mem_addr_u qa;
    wa.flat = wr_addr;
    qa.flat = dq_addr;
    qb      = qa.split.bank;
    b       = ref_alloc(wr_en, wa.split.bank);
    bp_exp  = (b < 0);
    ma_exp  = '0;
    rd_exp  = '0;
    if (rd_en) begin
      rd_exp.vld  = 1'b1;
      rd_exp.data = shadow[rd_addr]; // old word on a collision.
    end
    if (ma_en && b >= 0) begin
      ma_exp.vld             = 1'b1;
      ma_exp.addr.split.bank = BANK_BITS'(b);
      ma_exp.addr.split.row  = fl_rows[b][fl_head[b]];
      fl_head[b]             = (fl_head[b] + 1) % NUM_ROWS;
      fl_cnt[b]              = fl_cnt[b] - 1;
      shadow[ma_exp.addr.flat] = ma_data;
      last_grant             = ma_exp.addr.flat;
    end
    if (wr_en) begin
      shadow[wr_addr] = wr_data;
    end
    if (dq_en) begin
      fl_rows[qb][(fl_head[qb] + fl_cnt[qb]) % NUM_ROWS] = qa.split.row;
      fl_cnt[qb] = fl_cnt[qb] + 1;
    end
    ma_req.en        = ma_en;
    ma_req.data      = ma_data;
    wr_req.en        = wr_en;
    wr_req.addr.flat = wr_addr;
    wr_req.data      = wr_data;
    rd_req.en        = rd_en;
    rd_req.addr.flat = rd_addr;
    dq_req.en        = dq_en;
    dq_req.addr.flat = dq_addr;
    @(posedge clk);
    #1;
    drive_idle();
  endtask

  task automatic idle(input int n);
    repeat (n) step(1'b0, '0, 1'b0, '0, '0, 1'b0, '0, 1'b0, '0);
  endtask

  task automatic alloc(input logic [DATA_W-1:0] d);
    step(1'b1, d, 1'b0, '0, '0, 1'b0, '0, 1'b0, '0);
  endtask

  task automatic write_word(input logic [ADDR_BITS-1:0] a, input logic [DATA_W-1:0] d);
    step(1'b0, '0, 1'b1, a, d, 1'b0, '0, 1'b0, '0);
  endtask

  task automatic read_word(input logic [ADDR_BITS-1:0] a);
    step(1'b0, '0, 1'b0, '0, '0, 1'b1, a, 1'b0, '0);
  endtask

  task automatic dequeue(input logic [ADDR_BITS-1:0] a);
    step(1'b0, '0, 1'b0, '0, '0, 1'b0, '0, 1'b1, a);
  endtask

  task automatic expect_bp(input logic v);
    @(negedge clk);
    assert (ma_bp === v) else begin
      bp_errs++;
      $display("[ERROR] ma_bp got %h exp %h", ma_bp, v);
    end
    @(posedge clk);
    #1;
  endtask

  // every port is poked while the lists are built and none may take effect.
  task automatic do_reset();
    int n;
    rst = 1'b1;
    model_reset();
    drive_idle();
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    n   = 0;
    while (ready !== 1'b1 && n < NUM_ROWS + 2) begin
      ma_req.en        = 1'b1;
      ma_req.data      = 16'hdead;
      wr_req.en        = 1'b1;
      wr_req.addr.flat = 6'h11;
      wr_req.data      = 16'hbeef;
      rd_req.en        = 1'b1;
      dq_req.en        = 1'b1;
      @(posedge clk);
      #1;
      n++;
    end
    drive_idle();
    assert (ready === 1'b1) else begin
      misc_errs++;
      $display("ready did not rise within %0d cycles after reset", NUM_ROWS + 2);
    end
    assert (n >= NUM_ROWS) else begin
      misc_errs++;
      $display("ready rose after %0d cycles, before all %0d rows were linked", n, NUM_ROWS);
    end
  endtask

  task automatic print_summary();
    $display("errors: ma_resp %0d, rd_resp %0d, ma_bp %0d, other %0d",
             ma_errs, rd_errs, bp_errs, misc_errs);
  endtask

  always @(posedge clk) begin
    ma_pipe    = ma_exp;
    rd_pipe[1] = rd_pipe[0];
    rd_pipe[0] = rd_exp;
  end

  always @(negedge clk) begin
    if (!rst) begin
      assert (ma_resp.vld === ma_pipe.vld) else begin
        ma_errs++;
        $display("[ERROR] ma_resp.vld got %h exp %h", ma_resp.vld, ma_pipe.vld);
      end
      if (ma_pipe.vld) begin
        assert (ma_resp.addr.flat === ma_pipe.addr.flat) else begin
          ma_errs++;
          $display("[ERROR] ma_resp.addr got %h exp %h", ma_resp.addr.flat, ma_pipe.addr.flat);
        end
      end
      assert (rd_resp.vld === rd_pipe[1].vld) else begin
        rd_errs++;
        $display("[ERROR] rd_resp.vld got %h exp %h", rd_resp.vld, rd_pipe[1].vld);
      end
      if (rd_pipe[1].vld) begin
        assert (rd_resp.data === rd_pipe[1].data) else begin
          rd_errs++;
          $display("[ERROR] rd_resp.data got %h exp %h", rd_resp.data, rd_pipe[1].data);
        end
      end
      if (ready === 1'b1) begin
        assert (ma_bp === bp_exp) else begin
          bp_errs++;
          $display("[ERROR] ma_bp got %h exp %h", ma_bp, bp_exp);
        end
      end
    end
  end

  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
    print_summary();
    $display("Test failures found");
    $finish;
  end

  initial begin
    logic [15:0]          r;
    logic [DATA_W-1:0]    d;
    logic [DATA_W-1:0]    d2;
    logic [ADDR_BITS-1:0] a;
    logic [ADDR_BITS-1:0] granted [8];
    logic [ADDR_BITS-1:0] waddrs [6];
    ma_errs    = 0;
    rd_errs    = 0;
    bp_errs    = 0;
    misc_errs  = 0;
    lfsr       = 16'd83;
    ma_pipe    = '0;
    rd_pipe[0] = '0;
    rd_pipe[1] = '0;
    do_reset();

    for (int i = 0; i < 8; i++) begin
      rand_bits(DATA_W, r);
      alloc(r);
      granted[i] = last_grant;
    end
    for (int i = 0; i < 8; i++) begin
      read_word(granted[i]); // back to back with two in flight.
    end

    for (int i = 0; i < 6; i++) begin
      rand_bits(ADDR_BITS, r);
      waddrs[i] = r[ADDR_BITS-1:0];
      rand_bits(DATA_W, r);
      write_word(waddrs[i], r);
    end
    for (int i = 0; i < 6; i++) begin
      read_word(waddrs[i]);
    end
    rand_bits(DATA_W, r);
    step(1'b0, '0, 1'b1, waddrs[0], r, 1'b1, waddrs[0], 1'b0, '0);
    read_word(waddrs[0]);

    // freed rows queue up behind bank 0's remaining rows.
    dequeue(granted[3]);
    dequeue(granted[1]);
    dequeue(granted[5]);
    for (int i = 0; i < 12; i++) begin
      rand_bits(DATA_W, r);
      alloc(r);
    end
    read_word(last_grant);

    idle(3);
    do_reset();
    for (int i = 0; i < 60; i++) begin
      rand_bits(DATA_W, r);
      alloc(r);
    end
    expect_bp(1'b1);
    rand_bits(DATA_W, d);
    alloc(d); // dropped under back-pressure.
    dequeue({2'd2, 4'd5});
    expect_bp(1'b0);
    alloc(d);
    read_word(last_grant);

    for (int i = 0; i < 4; i++) begin
      dequeue({2'd0, ROW_BITS'(i)});
      dequeue({2'd1, ROW_BITS'(i)});
    end
    rand_bits(DATA_W, d);
    rand_bits(DATA_W, d2);
    step(1'b1, d, 1'b1, {2'd0, 4'd9}, d2, 1'b0, '0, 1'b0, '0);
    a = last_grant;
    read_word({2'd0, 4'd9});
    read_word(a);
    idle(3);

    print_summary();
    if (ma_errs + rd_errs + bp_errs + misc_errs == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* build.f */
rtl/flmem_pkg.sv
rtl/init_sequencer.sv
rtl/bank_free_list.sv
rtl/alloc_arbiter.sv
rtl/bank_data_mem.sv
rtl/read_return.sv
rtl/flmem_top.sv
test/tb_flmem.sv
